// ==== logic/pdes_pkg.sv ====
package pdes_pkg;

   // event field widths
   localparam int TIME_WID = 16;
   localparam int LP_WID   = 8;
   localparam int MSG_WID  = 25;

   // message layout, time at the bottom and the anti flag on top
   localparam int TIME_LSB = 0;
   localparam int LP_LSB   = 16;
   localparam int ANTI_BIT = 24;

   // initial event count width
   localparam int INIT_WID = 9;

   // sorted queue entries
   localparam int QUEUE_DEPTH = 16;

   // run statistics
   localparam int CNT_WID = 32;

   // neutral value when taking a minimum
   localparam logic [TIME_WID-1:0] TIME_MAX = {TIME_WID{1'b1}};

   // run states of the scheduler
   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      INIT     = 3'd1,
      READY    = 3'd2,
      RUNNING  = 3'd3,
      FINISHED = 3'd4
   } sched_state_e;

endpackage

// ==== logic/sched_fsm.sv ====
module sched_fsm (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           start,
   input  logic [pdes_pkg::TIME_WID-1:0]  sim_end,
   input  logic                           evt_in_vld,
   input  logic [pdes_pkg::MSG_WID-1:0]   evt_in,
   input  logic                           evt_req,
   input  logic                           cores_idle,
   input  logic [pdes_pkg::TIME_WID-1:0]  gvt,
   input  logic [pdes_pkg::LP_WID-1:0]    init_lp,
   input  logic                           init_done,
   input  logic                           empty,
   input  logic                           full,
   input  logic [pdes_pkg::MSG_WID-1:0]   head,
   output logic                           init_en,
   output logic                           enq,
   output logic [pdes_pkg::MSG_WID-1:0]   enq_data,
   output logic                           deq,
   output logic                           running,
   output logic                           run_start,
   output logic                           evt_out_vld,
   output logic [pdes_pkg::MSG_WID-1:0]   evt_out,
   output logic                           rtn_vld,
   output logic                           cleanup
);

   pdes_pkg::sched_state_e state;
   pdes_pkg::sched_state_e state_nxt;
   logic req_pend;
   logic null_msg;
   logic past_end;
   logic init_enq;
   logic run_enq;

   assign run_start = (state == pdes_pkg::IDLE) && start;
   assign init_en   = (state == pdes_pkg::INIT);
   assign running   = (state == pdes_pkg::RUNNING);
   assign past_end  = gvt > sim_end;

   // null message is an anti flag with lp 0 and time 0
   assign null_msg = evt_in[pdes_pkg::ANTI_BIT] && (evt_in[pdes_pkg::ANTI_BIT-1:0] == '0);

   // init events go in at time 0 as normal messages
   assign init_enq = init_en && !init_done;
   assign run_enq  = running && evt_in_vld && !full && !null_msg;
   assign enq      = init_enq || run_enq;
   assign enq_data = init_enq ? {1'b0, init_lp, {pdes_pkg::TIME_WID{1'b0}}} : evt_in;

   // an enqueue in the same cycle wins over a dispatch
   assign deq = req_pend && running && !enq && !empty && !past_end;

   always_comb begin
      state_nxt = state;
      case (state)
         pdes_pkg::IDLE:     if (start) state_nxt = pdes_pkg::INIT;
         pdes_pkg::INIT:     if (init_done) state_nxt = pdes_pkg::READY;
         pdes_pkg::READY:    state_nxt = pdes_pkg::RUNNING;
         pdes_pkg::RUNNING:  if (past_end && cores_idle) state_nxt = pdes_pkg::FINISHED;
         pdes_pkg::FINISHED: state_nxt = pdes_pkg::IDLE;
         default:            state_nxt = pdes_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= pdes_pkg::IDLE;
         req_pend    <= 1'b0;
         evt_out_vld <= 1'b0;
         rtn_vld     <= 1'b0;
         cleanup     <= 1'b0;
      end else begin
         state       <= state_nxt;
         // request stays pending until a dispatch serves it
         req_pend    <= run_start ? 1'b0 : ((req_pend && !deq) || evt_req);
         evt_out_vld <= deq;
         // held until the next run starts
         rtn_vld     <= !run_start &&
                        (rtn_vld || (running && past_end) || full);
         cleanup     <= (state == pdes_pkg::FINISHED) || full;
      end
   end

   // head sampled in the decision cycle
   always_ff @(posedge clk) begin
      if (deq) begin
         evt_out <= head;
      end
   end

endmodule

// ==== logic/init_counter.sv ====
module init_counter (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           init_en,
   input  logic [pdes_pkg::INIT_WID-1:0]  num_init_events,
   input  logic [pdes_pkg::LP_WID-1:0]    lp_mask,
   output logic [pdes_pkg::LP_WID-1:0]    init_lp,
   output logic                           init_done
);

   logic [pdes_pkg::INIT_WID-1:0] count;

   // counts up while init runs, back to zero otherwise
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (init_en) begin
         if (!init_done) begin
            count <= count + 1'b1;
         end
      end else begin
         count <= '0;
      end
   end

   // lp id of the next initial event
   assign init_lp = count[pdes_pkg::LP_WID-1:0] & lp_mask;

   // a zero count is done straight away
   assign init_done = (count == num_init_events);

endmodule

// ==== logic/event_queue.sv ====
module event_queue (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           enq,
   input  logic [pdes_pkg::MSG_WID-1:0]   enq_data,
   input  logic                           deq,
   output logic [pdes_pkg::MSG_WID-1:0]   head,
   output logic                           empty,
   output logic                           full
);

   logic [pdes_pkg::MSG_WID-1:0]      slot     [pdes_pkg::QUEUE_DEPTH];
   logic [pdes_pkg::QUEUE_DEPTH-1:0]  slot_vld;
   logic [pdes_pkg::MSG_WID-1:0]      sh_slot  [pdes_pkg::QUEUE_DEPTH];
   logic [pdes_pkg::QUEUE_DEPTH-1:0]  sh_vld;
   logic [pdes_pkg::QUEUE_DEPTH-1:0]  stay;
   logic [pdes_pkg::MSG_WID-1:0]      nxt_slot [pdes_pkg::QUEUE_DEPTH];
   logic [pdes_pkg::QUEUE_DEPTH-1:0]  nxt_vld;
   logic                              deq_ok;
   logic                              enq_ok;

   // earlier time first, anti message first at equal time
   function automatic logic sorts_before(
      input logic [pdes_pkg::MSG_WID-1:0] a,
      input logic [pdes_pkg::MSG_WID-1:0] b
   );
      logic [pdes_pkg::TIME_WID-1:0] ta;
      logic [pdes_pkg::TIME_WID-1:0] tb;
      ta = a[pdes_pkg::TIME_LSB +: pdes_pkg::TIME_WID];
      tb = b[pdes_pkg::TIME_LSB +: pdes_pkg::TIME_WID];
      return (ta < tb) ||
             ((ta == tb) && a[pdes_pkg::ANTI_BIT] && !b[pdes_pkg::ANTI_BIT]);
   endfunction

   assign head  = slot[0];
   assign empty = !slot_vld[0];
   assign full  = slot_vld[pdes_pkg::QUEUE_DEPTH-1];

   // a removal frees a slot for an insertion in the same cycle
   assign deq_ok = deq && !empty;
   assign enq_ok = enq && (!full || deq_ok);

   // queue after removal of the head
   always_comb begin
      for (int i = 0; i < pdes_pkg::QUEUE_DEPTH - 1; i++) begin
         sh_slot[i] = deq_ok ? slot[i+1] : slot[i];
         sh_vld[i]  = deq_ok ? slot_vld[i+1] : slot_vld[i];
      end
      sh_slot[pdes_pkg::QUEUE_DEPTH-1] = slot[pdes_pkg::QUEUE_DEPTH-1];
      sh_vld[pdes_pkg::QUEUE_DEPTH-1]  = deq_ok ? 1'b0 : slot_vld[pdes_pkg::QUEUE_DEPTH-1];
   end

   // entries ahead of the new event; equal keys stay ahead, keeping arrival order
   always_comb begin
      for (int i = 0; i < pdes_pkg::QUEUE_DEPTH; i++) begin
         stay[i] = sh_vld[i] && !sorts_before(enq_data, sh_slot[i]);
      end
   end

   // insert at the first slot not kept, shift the rest back by one
   always_comb begin
      nxt_slot[0] = (!enq_ok || stay[0]) ? sh_slot[0] : enq_data;
      nxt_vld[0]  = sh_vld[0] || enq_ok;
      for (int i = 1; i < pdes_pkg::QUEUE_DEPTH; i++) begin
         if (!enq_ok || stay[i]) begin
            nxt_slot[i] = sh_slot[i];
         end else if (stay[i-1]) begin
            nxt_slot[i] = enq_data;
         end else begin
            nxt_slot[i] = sh_slot[i-1];
         end
         nxt_vld[i] = sh_vld[i] || (enq_ok && sh_vld[i-1]);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_vld <= '0;
      end else begin
         slot_vld <= nxt_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (enq_ok || deq_ok) begin
         for (int i = 0; i < pdes_pkg::QUEUE_DEPTH; i++) begin
            slot[i] <= nxt_slot[i];
         end
      end
   end

endmodule

// ==== logic/gvt_tracker.sv ====
module gvt_tracker (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           running,
   input  logic                           run_start,
   input  logic                           min_time_vld,
   input  logic [pdes_pkg::TIME_WID-1:0]  min_time,
   input  logic [pdes_pkg::MSG_WID-1:0]   head,
   input  logic                           empty,
   output logic [pdes_pkg::TIME_WID-1:0]  gvt
);

   logic [pdes_pkg::TIME_WID-1:0] q_time;
   logic [pdes_pkg::TIME_WID-1:0] gvt_nxt;

   // empty queue puts no bound on gvt
   assign q_time = empty ? pdes_pkg::TIME_MAX : head[pdes_pkg::TIME_LSB +: pdes_pkg::TIME_WID];

   // smaller of core side and queue side
   assign gvt_nxt = (min_time < q_time) ? min_time : q_time;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (run_start) begin
         gvt <= '0;
      end else if (running && min_time_vld) begin
         gvt <= gvt_nxt;
      end
   end

endmodule

// ==== logic/run_stats.sv ====
module run_stats (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           run_start,
   input  logic                           running,
   input  logic                           evt_out_vld,
   input  logic [pdes_pkg::MSG_WID-1:0]   evt_out,
   output logic [pdes_pkg::CNT_WID-1:0]   total_cycles,
   output logic [pdes_pkg::CNT_WID-1:0]   total_events,
   output logic [pdes_pkg::CNT_WID-1:0]   total_antimsg
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         total_cycles  <= '0;
         total_events  <= '0;
         total_antimsg <= '0;
      end else if (run_start) begin
         total_cycles  <= '0;
         total_events  <= '0;
         total_antimsg <= '0;
      end else begin
         // cycles spent in the running state
         if (running) begin
            total_cycles <= total_cycles + 1'b1;
         end
         // dispatched events, and how many of them cancel earlier ones
         if (evt_out_vld) begin
            total_events <= total_events + 1'b1;
            if (evt_out[pdes_pkg::ANTI_BIT]) begin
               total_antimsg <= total_antimsg + 1'b1;
            end
         end
      end
   end

endmodule

// ==== logic/pdes_scheduler.sv ====
module pdes_scheduler (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           start,
   input  logic [pdes_pkg::INIT_WID-1:0]  num_init_events,
   input  logic [pdes_pkg::LP_WID-1:0]    lp_mask,
   input  logic [pdes_pkg::TIME_WID-1:0]  sim_end,
   input  logic                           evt_in_vld,
   input  logic [pdes_pkg::MSG_WID-1:0]   evt_in,
   input  logic                           evt_req,
   input  logic                           min_time_vld,
   input  logic [pdes_pkg::TIME_WID-1:0]  min_time,
   input  logic                           cores_idle,
   output logic                           evt_out_vld,
   output logic [pdes_pkg::MSG_WID-1:0]   evt_out,
   output logic [pdes_pkg::TIME_WID-1:0]  gvt,
   output logic                           rtn_vld,
   output logic                           cleanup,
   output logic [pdes_pkg::CNT_WID-1:0]   total_cycles,
   output logic [pdes_pkg::CNT_WID-1:0]   total_events,
   output logic [pdes_pkg::CNT_WID-1:0]   total_antimsg
);

   logic                          init_en;
   logic [pdes_pkg::LP_WID-1:0]   init_lp;
   logic                          init_done;
   logic                          enq;
   logic [pdes_pkg::MSG_WID-1:0]  enq_data;
   logic                          deq;
   logic [pdes_pkg::MSG_WID-1:0]  head;
   logic                          empty;
   logic                          full;
   logic                          running;
   logic                          run_start;

   sched_fsm fsm_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .start       (start),
      .sim_end     (sim_end),
      .evt_in_vld  (evt_in_vld),
      .evt_in      (evt_in),
      .evt_req     (evt_req),
      .cores_idle  (cores_idle),
      .gvt         (gvt),
      .init_lp     (init_lp),
      .init_done   (init_done),
      .empty       (empty),
      .full        (full),
      .head        (head),
      .init_en     (init_en),
      .enq         (enq),
      .enq_data    (enq_data),
      .deq         (deq),
      .running     (running),
      .run_start   (run_start),
      .evt_out_vld (evt_out_vld),
      .evt_out     (evt_out),
      .rtn_vld     (rtn_vld),
      .cleanup     (cleanup)
   );

   init_counter init_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .init_en         (init_en),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .init_lp         (init_lp),
      .init_done       (init_done)
   );

   event_queue queue_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (enq),
      .enq_data (enq_data),
      .deq      (deq),
      .head     (head),
      .empty    (empty),
      .full     (full)
   );

   gvt_tracker gvt_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .running      (running),
      .run_start    (run_start),
      .min_time_vld (min_time_vld),
      .min_time     (min_time),
      .head         (head),
      .empty        (empty),
      .gvt          (gvt)
   );

   run_stats stats_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .run_start     (run_start),
      .running       (running),
      .evt_out_vld   (evt_out_vld),
      .evt_out       (evt_out),
      .total_cycles  (total_cycles),
      .total_events  (total_events),
      .total_antimsg (total_antimsg)
   );

endmodule

// ==== tb/sched_tests.svh ====
   // initial events come out in count order with masked lp ids
   task automatic init_events_dispatch();
      start_run(6, 8'h05);
      for (int i = 0; i < 6; i++) begin
         request_and_take();
      end
      compare(total_events, exp_events, "total_events after init");
   endtask

   // narrow time range so anti and normal events share timestamps
   task automatic events_in_order();
      logic [pdes_pkg::MSG_WID-1:0] m;
      logic [31:0] r;
      logic [31:0] t;
      for (int i = 0; i < 12; i++) begin
         r = $urandom;
         t = $urandom_range(3, 1);
         m = '0;
         m[pdes_pkg::ANTI_BIT] = r[0];
         m[pdes_pkg::LP_LSB +: pdes_pkg::LP_WID] = r[8 +: pdes_pkg::LP_WID];
         m[pdes_pkg::TIME_LSB +: pdes_pkg::TIME_WID] = t[pdes_pkg::TIME_WID-1:0];
         send_event(m);
      end
      for (int i = 0; i < 12; i++) begin
         request_and_take();
      end
   endtask

   // a null message leaves a request on an empty queue pending
   task automatic null_and_pending();
      evt_req = 1'b1;
      @(negedge clk);
      evt_req = 1'b0;
      for (int i = 0; i < 12; i++) begin
         if (i == 6) begin
            send_event({1'b1, 8'h00, 16'h0000});
         end
         compare(32'(evt_out_vld), 0, "evt_out_vld with nothing queued");
         @(negedge clk);
      end
      send_event({1'b0, 8'h2a, 16'h0030});
      take_dispatch();
   endtask

   task automatic gvt_follows_min();
      strobe_min_time(16'h0040);
      send_event({1'b0, 8'h03, 16'h0020});
      send_event({1'b1, 8'h04, 16'h0035});
      strobe_min_time(16'h0050);
      strobe_min_time(16'h0010);
      request_and_take();
      strobe_min_time(16'h0050);
      request_and_take();
      strobe_min_time(16'h0060);
   endtask

   // gvt past sim_end with idle cores ends the run
   task automatic finish_and_stats();
      int unsigned span;
      cores_idle = 1'b1;
      strobe_min_time(sim_end + 16'd1);
      wait_for("cleanup");
      span = cycle_no - start_cycle;
      compare(32'(rtn_vld), 1, "rtn_vld at cleanup");
      @(negedge clk);
      for (int i = 0; i < 6; i++) begin
         compare(32'(cleanup), 0, "cleanup after its strobe");
         @(negedge clk);
      end
      compare(total_events, exp_events, "total_events");
      compare(total_antimsg, exp_anti, "total_antimsg");
      compare(32'(total_cycles != 0), 1, "total_cycles nonzero");
      compare(32'(total_cycles <= span), 1, "total_cycles within run length");
   endtask

   task automatic queue_overflow();
      logic [31:0] r;
      start_run(0, 8'hff);
      compare(32'(rtn_vld), 0, "rtn_vld after start");
      for (int i = 0; i < pdes_pkg::QUEUE_DEPTH; i++) begin
         compare(32'(cleanup), 0, "cleanup before the queue is full");
         r = $urandom;
         send_event({1'b0, r[23:16], r[15:0]});
      end
      wait_for("cleanup");
      compare(32'(rtn_vld), 1, "rtn_vld on overflow");
      // every queued event is still held and comes out in order
      for (int i = 0; i < pdes_pkg::QUEUE_DEPTH; i++) begin
         request_and_take();
      end
   endtask

// ==== tb/tb_pdes_scheduler.sv ====
module tb_pdes_scheduler;
   timeunit 1ns;
   timeprecision 1ps;

   logic                          clk;
   logic                          rst_n;
   logic                          start, evt_in_vld, evt_req, min_time_vld, cores_idle;
   logic                          evt_out_vld, rtn_vld, cleanup;
   logic [pdes_pkg::INIT_WID-1:0] num_init_events;
   logic [pdes_pkg::LP_WID-1:0]   lp_mask;
   logic [pdes_pkg::TIME_WID-1:0] sim_end, min_time, gvt;
   logic [pdes_pkg::MSG_WID-1:0]  evt_in, evt_out;
   logic [pdes_pkg::CNT_WID-1:0]  total_cycles, total_events, total_antimsg;

   // expected queue contents in dispatch order
   logic [pdes_pkg::MSG_WID-1:0]  model_q[$];
   int unsigned                   exp_events;
   int unsigned                   exp_anti;
   int unsigned                   cycle_no = 0;
   int unsigned                   start_cycle;
   int                            timeout_cycles = 200;

   pdes_scheduler dut_i (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_no <= cycle_no + 1;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
      if (actual !== expected) begin
         abort_run($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                             $time, what, actual, expected));
      end
   endtask

   // polls at falling edges for a dispatch, the cleanup strobe or a running DUT
   task automatic wait_for(input string what);
      logic hit;
      for (int n = 0; n <= timeout_cycles; n++) begin
         hit = (what == "dispatch") ? evt_out_vld :
               (what == "cleanup") ? cleanup : (total_cycles != 0);
         if (hit) begin
            return;
         end
         @(negedge clk);
      end
      abort_run({"timed out waiting for ", what});
   endtask

   // time first, then anti messages ahead of normal ones
   function automatic logic [pdes_pkg::TIME_WID:0] sort_key(
      input logic [pdes_pkg::MSG_WID-1:0] m);
      return {m[pdes_pkg::TIME_LSB +: pdes_pkg::TIME_WID], !m[pdes_pkg::ANTI_BIT]};
   endfunction

   // new event goes behind every entry with an equal or smaller key
   task automatic model_insert(input logic [pdes_pkg::MSG_WID-1:0] m);
      int pos = 0;
      while (pos < model_q.size() && sort_key(model_q[pos]) <= sort_key(m)) begin
         pos++;
      end
      model_q.insert(pos, m);
   endtask

   // null message never reaches the model
   task automatic send_event(input logic [pdes_pkg::MSG_WID-1:0] m);
      evt_in_vld = 1'b1;
      evt_in = m;
      @(negedge clk);
      evt_in_vld = 1'b0;
      if (m != {1'b1, {(pdes_pkg::MSG_WID-1){1'b0}}}) begin
         model_insert(m);
      end
   endtask

   task automatic take_dispatch();
      logic [pdes_pkg::MSG_WID-1:0] exp_msg;
      wait_for("dispatch");
      if (model_q.size() == 0) begin
         abort_run("an event was dispatched while none was expected");
      end
      exp_msg = model_q.pop_front();
      compare(32'(evt_out), 32'(exp_msg), "dispatched event");
      exp_events++;
      if (exp_msg[pdes_pkg::ANTI_BIT]) begin
         exp_anti++;
      end
      @(negedge clk);
   endtask

   task automatic request_and_take();
      evt_req = 1'b1;
      @(negedge clk);
      evt_req = 1'b0;
      take_dispatch();
   endtask

   // gvt follows the smaller of min_time and the queue head
   task automatic strobe_min_time(input logic [pdes_pkg::TIME_WID-1:0] t);
      logic [pdes_pkg::TIME_WID-1:0] q_time;
      q_time = (model_q.size() == 0) ? pdes_pkg::TIME_MAX :
               model_q[0][pdes_pkg::TIME_LSB +: pdes_pkg::TIME_WID];
      min_time_vld = 1'b1;
      min_time = t;
      @(negedge clk);
      min_time_vld = 1'b0;
      compare(32'(gvt), 32'((t < q_time) ? t : q_time), "gvt after min_time strobe");
   endtask

   task automatic start_run(input int count, input logic [pdes_pkg::LP_WID-1:0] mask);
      logic [pdes_pkg::MSG_WID-1:0] m;
      num_init_events = count[pdes_pkg::INIT_WID-1:0];
      lp_mask = mask;
      start = 1'b1;
      start_cycle = cycle_no;
      @(negedge clk);
      start = 1'b0;
      model_q.delete();
      exp_events = 0;
      exp_anti = 0;
      // init events at time 0 with the masked count as lp id
      for (int i = 0; i < count; i++) begin
         m = '0;
         m[pdes_pkg::LP_LSB +: pdes_pkg::LP_WID] = i[pdes_pkg::LP_WID-1:0] & mask;
         model_insert(m);
      end
      wait_for("running");
   endtask

   `include "sched_tests.svh"

   initial begin
      void'($urandom(32'h2b64_20d0));
      rst_n = 1'b0;
      {start, evt_in_vld, evt_req, min_time_vld, cores_idle} = '0;
      {evt_in, min_time, num_init_events, lp_mask} = '0;
      sim_end = 16'h0100;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      init_events_dispatch();
      events_in_order();
      null_and_pending();
      gvt_follows_min();
      finish_and_stats();
      queue_overflow();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+tb
logic/pdes_pkg.sv
logic/sched_fsm.sv
logic/init_counter.sv
logic/event_queue.sv
logic/gvt_tracker.sv
logic/run_stats.sv
logic/pdes_scheduler.sv
tb/tb_pdes_scheduler.sv

// ==== Makefile ====
TOP = tb_pdes_scheduler

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f all.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "=== PASS ===" run.log

clean:
	rm -rf obj_dir run.log
